// File: build.f
common/exc_pkg.sv
hw/exception/exc_slot_encode.sv
hw/exception/exception_ctrl.sv
hw/cp0/cp0_regs.sv
hw/exc_top.sv
verification/exc_top_sva.sv
verification/tb_exc_top.sv

// File: Bender.yml
package:
  name: exc_top

sources:
  - common/exc_pkg.sv
  - hw/exception/exc_slot_encode.sv
  - hw/exception/exception_ctrl.sv
  - hw/cp0/cp0_regs.sv
  - hw/exc_top.sv
  - target: simulation
    files:
      - verification/exc_top_sva.sv
      - verification/tb_exc_top.sv

// File: verification/tb_exc_top.sv
`timescale 1ns/10ps

module tb_exc_top;
    import exc_pkg::*;

    localparam addr_t EXC_BASE    = 32'hbfc0_0000;
    localparam int    COUNT_DIV   = 2;
    localparam int    CLK_PERIOD  = 4;
    localparam int    TEST_CYCLES = 140;
    localparam int    MARGIN_NS   = 400;

    // Expected record per exception kind, in the order used by flags_for().
    localparam exccode_t KIND_CODE [14] = '{EXC_TLBL, EXC_TLBL, EXC_ADEL, EXC_RI, EXC_OV,
        EXC_SYS, EXC_BP, EXC_TLBL, EXC_TLBL, EXC_TLBS, EXC_TLBS, EXC_ADEL, EXC_ADES, EXC_MOD};
    localparam logic KIND_REFILL [14] = '{1, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0};
    localparam int   KIND_BAD [14]    = '{0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 2, 2, 0}; // 1 PC, 2 data.

    logic        clk;
    logic        rst_n;
    slot_t       slot_a;
    slot_t       slot_b;
    logic        refetch;
    logic        cp0_we;
    cp0_addr_t   cp0_waddr;
    logic [31:0] cp0_wdata;
    cp0_addr_t   cp0_raddr;
    logic [31:0] cp0_rdata;
    logic [5:0]  hw_int;
    logic        redirect_valid;
    addr_t       redirect_pc;
    logic        flush;
    logic        int_pending;
    logic [31:0] lcg_state;

    exc_top #(
        .EXC_BASE  (EXC_BASE),
        .COUNT_DIV (COUNT_DIV)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .slot_a         (slot_a),
        .slot_b         (slot_b),
        .refetch        (refetch),
        .cp0_we         (cp0_we),
        .cp0_waddr      (cp0_waddr),
        .cp0_wdata      (cp0_wdata),
        .cp0_raddr      (cp0_raddr),
        .cp0_rdata      (cp0_rdata),
        .hw_int         (hw_int),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .int_pending    (int_pending)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic addr_t rand_pc();
        addr_t v;
        v = lcg_next();
        return {v[31:2], 2'b00};
    endfunction

    function automatic exc_flags_t flags_for(input int kind);
        exc_flags_t f;
        f = '0;
        case (kind)
            0:  f.i_refill_tlbl  = 1'b1;
            1:  f.i_invalid_tlbl = 1'b1;
            2:  f.inst_adel      = 1'b1;
            3:  f.ri             = 1'b1;
            4:  f.overflow       = 1'b1;
            5:  f.syscall        = 1'b1;
            6:  f.brk            = 1'b1;
            7:  f.d_refill_tlbl  = 1'b1;
            8:  f.d_invalid_tlbl = 1'b1;
            9:  f.d_refill_tlbs  = 1'b1;
            10: f.d_invalid_tlbs = 1'b1;
            11: f.data_adel      = 1'b1;
            12: f.data_ades      = 1'b1;
            default: f.modify    = 1'b1;
        endcase
        return f;
    endfunction

    function automatic slot_t make_slot(input exc_flags_t f, input logic ds);
        slot_t s;
        s.valid         = 1'b1;
        s.pc            = rand_pc();
        s.badvaddr      = lcg_next();
        s.in_delay_slot = ds;
        s.flags         = f;
        return s;
    endfunction

    task automatic peek_cp0(input cp0_addr_t addr, output logic [31:0] data);
        cp0_raddr = addr;
        #0.5;
        data = cp0_rdata;
    endtask

    task automatic read_cp0(input cp0_addr_t addr, output logic [31:0] data);
        @(negedge clk);
        peek_cp0(addr, data);
    endtask

    task automatic write_cp0(input cp0_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        cp0_we    = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        @(negedge clk);
        cp0_we    = 1'b0;
    endtask

    // One commit cycle; the redirect is combinational, so it is checked in the same cycle.
    task automatic commit_check(input slot_t a, input slot_t b, input logic rf,
                                input logic exp_valid, input addr_t exp_pc);
        @(negedge clk);
        slot_a  = a;
        slot_b  = b;
        refetch = rf;
        #1;
        compare_bit("redirect_valid", redirect_valid, exp_valid);
        compare_bit("flush", flush, exp_valid);
        if (exp_valid) compare_addr("redirect_pc", redirect_pc, exp_pc);
        @(negedge clk);
        slot_a  = '0;
        slot_b  = '0;
        refetch = 1'b0;
    endtask

    task automatic check_record(input exccode_t code, input addr_t epc_exp, input logic bd);
        logic [31:0] d;
        read_cp0(CP0_CAUSE, d);
        compare_word("cause_exccode", {27'b0, d[6:2]}, {27'b0, code});
        compare_bit("cause_bd", d[31], bd);
        read_cp0(CP0_EPC, d);
        compare_addr("epc", d, epc_exp);
    endtask

    task automatic test_reset_state();
        logic [31:0] d;
        @(negedge clk);
        compare_bit("redirect_valid", redirect_valid, 1'b0);
        compare_bit("flush", flush, 1'b0);
        compare_bit("int_pending", int_pending, 1'b0);
        read_cp0(CP0_STATUS, d);
        compare_bit("status_exl", d[1], 1'b1);
        compare_bit("status_ie", d[0], 1'b0);
        read_cp0(CP0_CAUSE, d);
        compare_word("cause", d, 32'h0);
        read_cp0(CP0_EPC, d);
        compare_addr("epc", d, 32'h0);
        read_cp0(CP0_COMPARE, d);
        compare_word("compare", d, 32'h0);
    endtask

    task automatic test_each_exception();
        slot_t       a;
        addr_t       vec;
        logic [31:0] d;
        for (int k = 0; k < 14; k++) begin
            a   = make_slot(flags_for(k), 1'b0);
            vec = EXC_BASE + (KIND_REFILL[k] ? VEC_OFS_REFILL : VEC_OFS_GENERAL);
            commit_check(a, '0, 1'b0, 1'b1, vec);
            check_record(KIND_CODE[k], a.pc, 1'b0);
            if (KIND_BAD[k] != 0) begin
                read_cp0(CP0_BADVADDR, d);
                compare_addr("badvaddr", d, (KIND_BAD[k] == 1) ? a.pc : a.badvaddr);
            end
        end
    endtask

    task automatic test_priority();
        exc_flags_t  f;
        slot_t       a;
        slot_t       b;
        logic [31:0] prev_epc;
        logic [31:0] d;
        f    = '0;
        f.ri = 1'b1;
        f.syscall = 1'b1;
        a = make_slot(f, 1'b0);
        commit_check(a, '0, 1'b0, 1'b1, EXC_BASE + VEC_OFS_GENERAL);
        check_record(EXC_RI, a.pc, 1'b0);
        a = make_slot(flags_for(5), 1'b0);
        b = make_slot(flags_for(6), 1'b0);
        commit_check(a, b, 1'b0, 1'b1, EXC_BASE + VEC_OFS_GENERAL);
        check_record(EXC_SYS, a.pc, 1'b0);
        a = make_slot('0, 1'b0);    // Valid but clean older slot.
        b = make_slot(flags_for(3), 1'b0);
        commit_check(a, b, 1'b0, 1'b1, EXC_BASE + VEC_OFS_GENERAL);
        check_record(EXC_RI, b.pc, 1'b0);
        read_cp0(CP0_EPC, prev_epc);
        a = make_slot(flags_for(5), 1'b0);
        b = make_slot(flags_for(6), 1'b0);
        commit_check(a, b, 1'b1, 1'b1, a.pc);
        read_cp0(CP0_EPC, d);
        compare_addr("epc", d, prev_epc);
    endtask

    task automatic test_delay_slot();
        slot_t a;
        a = make_slot(flags_for(4), 1'b1);
        commit_check(a, '0, 1'b0, 1'b1, EXC_BASE + VEC_OFS_GENERAL);
        check_record(EXC_OV, a.pc - 32'd4, 1'b1);
    endtask

    task automatic test_eret();
        exc_flags_t  f;
        slot_t       a;
        addr_t       target;
        logic [31:0] d;
        target = rand_pc();
        write_cp0(CP0_EPC, target);
        f      = '0;
        f.eret = 1'b1;
        a = make_slot(f, 1'b0);
        commit_check(a, '0, 1'b0, 1'b1, target);
        read_cp0(CP0_STATUS, d);
        compare_bit("status_exl", d[1], 1'b0);
    endtask

    task automatic test_interrupt();
        slot_t       a;
        logic [31:0] d;
        write_cp0(CP0_STATUS, 32'h0000_0401);
        @(negedge clk);
        hw_int = 6'b000001;
        #0.5;
        compare_bit("int_pending", int_pending, 1'b0);
        @(negedge clk);
        compare_bit("int_pending", int_pending, 1'b0);  // Cause.IP has only just sampled hw_int.
        @(negedge clk);
        compare_bit("int_pending", int_pending, 1'b1);
        a = make_slot('0, 1'b0);
        commit_check(a, '0, 1'b0, 1'b1, EXC_BASE + VEC_OFS_GENERAL);
        hw_int = '0;
        check_record(EXC_INT, a.pc, 1'b0);
        read_cp0(CP0_STATUS, d);
        compare_bit("status_exl", d[1], 1'b1);
        compare_bit("int_pending", int_pending, 1'b0);
    endtask

    task automatic test_timer();
        logic [31:0] d;
        logic [31:0] target;
        logic        seen;
        read_cp0(CP0_COUNT, d);
        target = d + 32'd6;
        write_cp0(CP0_COMPARE, target);
        seen = 1'b0;
        for (int n = 0; n < 8 * COUNT_DIV + 4 && !seen; n++) begin
            read_cp0(CP0_CAUSE, d);
            if (d[15]) begin
                seen = 1'b1;
                peek_cp0(CP0_COUNT, d);
                compare_word("count", d, target);
            end
        end
        if (!seen) begin
            $display("Timer interrupt IP7 did not appear within the wait limit");
            abort_run();
        end
        write_cp0(CP0_COMPARE, target);    // Rewriting Compare acknowledges the timer.
        read_cp0(CP0_CAUSE, d);
        compare_bit("cause_ip7", d[15], 1'b0);
    endtask

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Watchdog expired before the tests completed");
        abort_run();
    end

    always @(negedge clk) begin
        if (DUT.u_sva.err_count != 0) begin
            $display("A concurrent assertion failed");
            abort_run();
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        slot_a    = '0;
        slot_b    = '0;
        refetch   = 1'b0;
        cp0_we    = 1'b0;
        cp0_waddr = '0;
        cp0_wdata = '0;
        cp0_raddr = '0;
        hw_int    = '0;
        lcg_state = 32'hcfac;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_each_exception();
        test_priority();
        test_delay_slot();
        test_eret();
        test_interrupt();
        test_timer();
        @(negedge clk);
        if (DUT.u_sva.err_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Concurrent assertions failed during the run");
            abort_run();
        end
    end

endmodule

// File: verification/exc_top_sva.sv
`timescale 1ns/10ps

module exc_top_sva (
    input logic clk,
    input logic rst_n,
    input logic refetch,
    input logic slot_a_valid,
    input logic slot_b_valid,
    input logic redirect_valid,
    input logic flush,
    input logic int_pending,
    input logic status_exl
);
    int err_count = 0;

    a_flush_is_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        flush == redirect_valid)
        else begin
            $error("flush and redirect_valid differ");
            err_count++;
        end

    // With EXL set the core is already in an exception handler.
    a_no_int_in_exl: assert property (@(posedge clk) disable iff (!rst_n)
        status_exl |-> !int_pending)
        else begin
            $error("int_pending is high while Status.EXL is set");
            err_count++;
        end

    a_redirect_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> (refetch || slot_a_valid || slot_b_valid))
        else begin
            $error("Redirect without a refetch or a valid slot");
            err_count++;
        end

endmodule

bind exc_top exc_top_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .refetch        (refetch),
    .slot_a_valid   (slot_a.valid),
    .slot_b_valid   (slot_b.valid),
    .redirect_valid (redirect_valid),
    .flush          (flush),
    .int_pending    (int_pending),
    .status_exl     (u_cp0.status_exl)
);

// File: hw/exc_top.sv
`timescale 1ns/10ps

module exc_top #(
    parameter exc_pkg::addr_t EXC_BASE  = 32'hbfc0_0000,
    parameter int             COUNT_DIV = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  exc_pkg::slot_t     slot_a,
    input  exc_pkg::slot_t     slot_b,
    input  logic               refetch,
    input  logic               cp0_we,
    input  exc_pkg::cp0_addr_t cp0_waddr,
    input  logic [31:0]        cp0_wdata,
    input  exc_pkg::cp0_addr_t cp0_raddr,
    output logic [31:0]        cp0_rdata,
    input  logic [5:0]         hw_int,
    output logic               redirect_valid,
    output exc_pkg::addr_t     redirect_pc,
    output logic               flush,
    output logic               int_pending
);
    import exc_pkg::*;

    cp0_upd_t cp0_upd;
    addr_t    cp0_epc;

    // Commit decisions are combinational; CP0 takes the result on the next edge.
    exception_ctrl #(
        .EXC_BASE (EXC_BASE)
    ) u_exc_ctrl (
        .slot_a         (slot_a),
        .slot_b         (slot_b),
        .refetch        (refetch),
        .int_pending    (int_pending),
        .epc            (cp0_epc),
        .cp0_upd        (cp0_upd),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush)
    );

    cp0_regs #(
        .COUNT_DIV (COUNT_DIV)
    ) u_cp0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .cp0_upd     (cp0_upd),
        .we          (cp0_we),
        .waddr       (cp0_waddr),
        .wdata       (cp0_wdata),
        .raddr       (cp0_raddr),
        .rdata       (cp0_rdata),
        .hw_int      (hw_int),
        .epc         (cp0_epc),
        .int_pending (int_pending)
    );

endmodule

// File: hw/cp0/cp0_regs.sv
`timescale 1ns/10ps

module cp0_regs #(
    parameter int COUNT_DIV = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  exc_pkg::cp0_upd_t  cp0_upd,
    input  logic               we,
    input  exc_pkg::cp0_addr_t waddr,
    input  logic [31:0]        wdata,
    input  exc_pkg::cp0_addr_t raddr,
    output logic [31:0]        rdata,
    input  logic [5:0]         hw_int,
    output exc_pkg::addr_t     epc,
    output logic               int_pending
);
    import exc_pkg::*;

    localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

    logic [7:0]       status_im;
    logic             status_exl;
    logic             status_ie;
    logic             cause_bd;
    logic             cause_ti;
    logic [5:0]       cause_ip_hw;
    logic [1:0]       cause_ip_sw;
    logic [7:0]       cause_ip;
    exccode_t         cause_exccode;
    addr_t            badvaddr;
    logic [31:0]      count;
    logic [31:0]      compare;
    logic [DIV_W-1:0] div_cnt;
    logic             count_tick;
    logic             timer_hit;
    logic             exl_next;
    logic             int_cond;
    logic             wr_status;
    logic             wr_cause;
    logic             wr_epc;
    logic             wr_count;
    logic             wr_compare;

    assign wr_status  = we && (waddr == CP0_STATUS);
    assign wr_cause   = we && (waddr == CP0_CAUSE);
    assign wr_epc     = we && (waddr == CP0_EPC);
    assign wr_count   = we && (waddr == CP0_COUNT);
    assign wr_compare = we && (waddr == CP0_COMPARE);

    // TI is raised on the tick that steps Count onto Compare.
    assign count_tick = (div_cnt == DIV_W'(COUNT_DIV - 1));
    assign timer_hit  = count_tick && !wr_count && (count + 32'd1 == compare);

    assign cause_ip = {cause_ip_hw[5] | cause_ti, cause_ip_hw[4:0], cause_ip_sw};
    assign int_cond = status_ie & ~status_exl & (|(cause_ip & status_im));

    always_comb begin
        exl_next = status_exl;
        if (wr_status) exl_next = wdata[1];
        if (cp0_upd.update_ena) begin
            exl_next = 1'b1;    // Taking an exception wins over a same-cycle mtc0.
        end else if (cp0_upd.cls_exl) begin
            exl_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            count   <= '0;
        end else if (wr_count) begin
            div_cnt <= '0;
            count   <= wdata;
        end else if (count_tick) begin
            div_cnt <= '0;
            count   <= count + 32'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            compare  <= '0;
            cause_ti <= 1'b0;
        end else if (wr_compare) begin
            compare  <= wdata;
            cause_ti <= 1'b0;   // Writing Compare acknowledges the timer.
        end else if (timer_hit) begin
            cause_ti <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_im   <= '0;
            status_ie   <= 1'b0;
            status_exl  <= 1'b1;
            int_pending <= 1'b0;
        end else begin
            if (wr_status) begin
                status_im <= wdata[15:8];
                status_ie <= wdata[0];
            end
            status_exl  <= exl_next;
            int_pending <= int_cond & ~exl_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cause_bd      <= 1'b0;
            cause_ip_hw   <= '0;
            cause_ip_sw   <= '0;
            cause_exccode <= '0;
            epc           <= '0;
        end else begin
            cause_ip_hw <= hw_int;
            if (wr_cause) cause_ip_sw <= wdata[9:8];
            if (wr_epc) epc <= wdata;
            if (cp0_upd.update_ena) begin
                cause_bd      <= cp0_upd.bd;
                cause_exccode <= cp0_upd.code;
                epc           <= cp0_upd.epc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cp0_upd.update_ena && cp0_upd.badvaddr_ena) badvaddr <= cp0_upd.badvaddr;
    end

    always_comb begin
        case (raddr)
            CP0_BADVADDR: rdata = badvaddr;
            CP0_COUNT:    rdata = count;
            CP0_COMPARE:  rdata = compare;
            CP0_STATUS:   rdata = {16'b0, status_im, 6'b0, status_exl, status_ie};
            CP0_CAUSE:    rdata = {cause_bd, cause_ti, 14'b0, cause_ip, 1'b0, cause_exccode, 2'b0};
            CP0_EPC:      rdata = epc;
            default:      rdata = '0;
        endcase
    end

endmodule

// File: hw/exception/exception_ctrl.sv
`timescale 1ns/10ps

module exception_ctrl #(
    parameter exc_pkg::addr_t EXC_BASE = 32'hbfc0_0000
) (
    input  exc_pkg::slot_t    slot_a,
    input  exc_pkg::slot_t    slot_b,
    input  logic              refetch,
    input  logic              int_pending,
    input  exc_pkg::addr_t    epc,
    output exc_pkg::cp0_upd_t cp0_upd,
    output logic              redirect_valid,
    output exc_pkg::addr_t    redirect_pc,
    output logic              flush
);
    import exc_pkg::*;

    exc_rec_t rec_a;
    exc_rec_t rec_b;
    exc_rec_t rec_sel;
    slot_t    slot_sel;
    addr_t    slot_epc;
    addr_t    vector;
    logic     take_int;
    logic     exc_a;
    logic     exc_b;

    exc_slot_encode u_enc_a (
        .flags    (slot_a.flags),
        .pc       (slot_a.pc),
        .badvaddr (slot_a.badvaddr),
        .rec      (rec_a)
    );

    exc_slot_encode u_enc_b (
        .flags    (slot_b.flags),
        .pc       (slot_b.pc),
        .badvaddr (slot_b.badvaddr),
        .rec      (rec_b)
    );

    // Interrupts ride on the older instruction only.
    assign take_int = slot_a.valid & int_pending;
    assign exc_a    = slot_a.valid & (rec_a.hit | int_pending);
    assign exc_b    = slot_b.valid & rec_b.hit;

    assign slot_sel = exc_a ? slot_a : slot_b;
    assign rec_sel  = exc_a ? rec_a : rec_b;
    assign slot_epc = slot_sel.in_delay_slot ? slot_sel.pc - 32'd4 : slot_sel.pc;
    assign vector   = EXC_BASE + ((rec_sel.refill & ~take_int) ? VEC_OFS_REFILL : VEC_OFS_GENERAL);

    assign redirect_valid = refetch | exc_a | exc_b;
    assign flush          = redirect_valid;

    always_comb begin
        cp0_upd     = '0;
        redirect_pc = vector;
        if (refetch) begin
            redirect_pc = slot_a.pc;    // Re-execute from the older slot.
        end else if (take_int) begin
            cp0_upd.update_ena = 1'b1;
            cp0_upd.code       = EXC_INT;
            cp0_upd.bd         = slot_a.in_delay_slot;
            cp0_upd.epc        = slot_epc;
        end else if (exc_a | exc_b) begin
            if (rec_sel.eret) begin
                cp0_upd.cls_exl = 1'b1;
                redirect_pc     = epc;
            end else begin
                cp0_upd.update_ena   = 1'b1;
                cp0_upd.code         = rec_sel.code;
                cp0_upd.bd           = slot_sel.in_delay_slot;
                cp0_upd.epc          = slot_epc;
                cp0_upd.badvaddr_ena = rec_sel.bad_ena;
                cp0_upd.badvaddr     = rec_sel.bad_addr;
            end
        end
    end

endmodule

// File: hw/exception/exc_slot_encode.sv
`timescale 1ns/10ps

module exc_slot_encode (
    input  exc_pkg::exc_flags_t flags,
    input  exc_pkg::addr_t      pc,
    input  exc_pkg::addr_t      badvaddr,
    output exc_pkg::exc_rec_t   rec
);
    import exc_pkg::*;

    // Fetch-side faults come first, then decode and execute, and the memory stage last.
    always_comb begin
        rec     = '0;
        rec.hit = |flags;
        if (flags.i_refill_tlbl) begin
            rec.code   = EXC_TLBL;
            rec.refill = 1'b1;
        end else if (flags.i_invalid_tlbl) begin
            rec.code = EXC_TLBL;
        end else if (flags.inst_adel) begin
            rec.code     = EXC_ADEL;
            rec.bad_ena  = 1'b1;
            rec.bad_addr = pc;      // The fetch address itself was bad.
        end else if (flags.ri) begin
            rec.code = EXC_RI;
        end else if (flags.overflow) begin
            rec.code = EXC_OV;
        end else if (flags.syscall) begin
            rec.code = EXC_SYS;
        end else if (flags.brk) begin
            rec.code = EXC_BP;
        end else if (flags.eret) begin
            rec.eret = 1'b1;
        end else if (flags.d_refill_tlbl) begin
            rec.code   = EXC_TLBL;
            rec.refill = 1'b1;
        end else if (flags.d_invalid_tlbl) begin
            rec.code = EXC_TLBL;
        end else if (flags.d_refill_tlbs) begin
            rec.code   = EXC_TLBS;
            rec.refill = 1'b1;
        end else if (flags.d_invalid_tlbs) begin
            rec.code = EXC_TLBS;
        end else if (flags.data_adel) begin
            rec.code     = EXC_ADEL;
            rec.bad_ena  = 1'b1;
            rec.bad_addr = badvaddr;
        end else if (flags.data_ades) begin
            rec.code     = EXC_ADES;
            rec.bad_ena  = 1'b1;
            rec.bad_addr = badvaddr;
        end else if (flags.modify) begin
            rec.code = EXC_MOD;
        end
    end

endmodule

// File: common/exc_pkg.sv
package exc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [4:0]  exccode_t;
    typedef logic [4:0]  cp0_addr_t;

    // One bit per exception source reported by the pipeline for a retiring instruction.
    typedef struct packed {
        logic eret;
        logic syscall;
        logic brk;
        logic inst_adel;
        logic data_adel;
        logic data_ades;
        logic overflow;
        logic ri;
        logic i_refill_tlbl;
        logic i_invalid_tlbl;
        logic d_refill_tlbl;
        logic d_invalid_tlbl;
        logic d_refill_tlbs;
        logic d_invalid_tlbs;
        logic modify;
    } exc_flags_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        addr_t      badvaddr;
        logic       in_delay_slot;
        exc_flags_t flags;
    } slot_t;

    typedef struct packed {
        logic     hit;
        exccode_t code;
        logic     refill;   // Take the TLB refill vector.
        logic     eret;
        logic     bad_ena;
        addr_t    bad_addr;
    } exc_rec_t;

    typedef struct packed {
        logic     update_ena;
        exccode_t code;
        logic     bd;
        addr_t    epc;
        logic     badvaddr_ena;
        addr_t    badvaddr;
        logic     cls_exl;  // ERET clears Status.EXL.
    } cp0_upd_t;

    localparam exccode_t EXC_INT  = 5'h00;
    localparam exccode_t EXC_MOD  = 5'h01;
    localparam exccode_t EXC_TLBL = 5'h02;
    localparam exccode_t EXC_TLBS = 5'h03;
    localparam exccode_t EXC_ADEL = 5'h04;
    localparam exccode_t EXC_ADES = 5'h05;
    localparam exccode_t EXC_SYS  = 5'h08;
    localparam exccode_t EXC_BP   = 5'h09;
    localparam exccode_t EXC_RI   = 5'h0a;
    localparam exccode_t EXC_OV   = 5'h0c;

    localparam addr_t VEC_OFS_REFILL  = 32'h0000_0200;
    localparam addr_t VEC_OFS_GENERAL = 32'h0000_0380;

    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

endpackage
